/* Makefile */
TOP = tb_icache_fe

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f icache_fe.f --Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* fetch_if.sv */
`timescale 1ns/1ps

interface fetch_if
  import icache_fe_pkg::*;
();

  logic        v;
  fetch_addr_u entry;
  logic        yumi;
  // Retires the oldest entry
  logic        commit;
  // Read pointer back to commit pointer
  logic        roll;

  modport queue (
    output v
    , output entry
    , input  yumi
    , input  commit
    , input  roll
  );

  modport cache (
    input    v
    , input  entry
    , output yumi
    , output commit
    , output roll
  );

endinterface

/* fetch_replay_fifo.sv */
`timescale 1ns/1ps

module fetch_replay_fifo
  import icache_fe_pkg::*;
(
  input    logic               clk_i
  , input  logic               arst_n_i

  , input  logic [VADDR_W-1:0] vaddr_i
  , input  logic [PTAG_W-1:0]  ptag_i
  , input  logic               vaddr_v_i
  , output logic               vaddr_ready_o

  , fetch_if.queue             fetch
);

  fetch_addr_u mem [QUEUE_DEPTH];

  // One extra bit on each pointer tells full from empty
  logic [QPTR_W:0] wptr_r;
  logic [QPTR_W:0] rptr_r;
  logic [QPTR_W:0] cptr_r;

  logic full;
  logic enq;

  // Space is measured against the commit pointer, not the read pointer
  assign full = (wptr_r[QPTR_W] != cptr_r[QPTR_W])
              && (wptr_r[QPTR_W-1:0] == cptr_r[QPTR_W-1:0]);

  assign vaddr_ready_o = ~full;
  assign enq           = vaddr_v_i & vaddr_ready_o;

  // Anything between read and write pointers is still to be presented
  assign fetch.v     = (rptr_r != wptr_r);
  assign fetch.entry = mem[rptr_r[QPTR_W-1:0]];

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem[wptr_r[QPTR_W-1:0]].req.ptag  <= ptag_i;
      mem[wptr_r[QPTR_W-1:0]].req.vaddr <= vaddr_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r <= '0;
    end else if (enq) begin
      wptr_r <= wptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cptr_r <= '0;
    end else if (fetch.commit) begin
      cptr_r <= cptr_r + 1'b1;
    end
  end

  // Rollback replays every uncommitted entry in order
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_r <= '0;
    end else if (fetch.roll) begin
      rptr_r <= cptr_r;
    end else if (fetch.yumi) begin
      rptr_r <= rptr_r + 1'b1;
    end
  end

endmodule

/* icache_fe.f */
icache_fe_pkg.sv
fetch_if.sv
miss_if.sv
fetch_replay_fifo.sv
icache_pipe.sv
icache_uce.sv
icache_fe_top.sv
icache_fe_properties.sv
tb_icache_fe.sv

/* icache_fe_pkg.sv */
package icache_fe_pkg;

  // Address widths
  localparam int VADDR_W = 12;
  localparam int PTAG_W  = 8;
  localparam int PADDR_W = PTAG_W + VADDR_W;

  localparam int INSTR_W = 32;
  localparam int BLOCK_W = 64;

  // Direct-mapped geometry
  localparam int SETS       = 16;
  localparam int INDEX_W    = $clog2(SETS);
  localparam int OFFSET_W   = $clog2(BLOCK_W / 8);
  localparam int BYTE_W     = $clog2(INSTR_W / 8);
  localparam int WORD_SEL_W = OFFSET_W - BYTE_W;
  localparam int CTAG_W     = PADDR_W - INDEX_W - OFFSET_W;

  // Fill beats from memory
  localparam int FILL_BEATS = 2;
  localparam int FILL_W     = BLOCK_W / FILL_BEATS;
  localparam int BEAT_W     = $clog2(FILL_BEATS);

  localparam int QUEUE_DEPTH = 8;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

  // Miss engine states
  localparam int UCE_STATE_W = 2;
  localparam logic [UCE_STATE_W-1:0] UCE_IDLE    = 2'd0;
  localparam logic [UCE_STATE_W-1:0] UCE_SEND    = 2'd1;
  localparam logic [UCE_STATE_W-1:0] UCE_COLLECT = 2'd2;
  localparam logic [UCE_STATE_W-1:0] UCE_FILL    = 2'd3;

  // Physical fetch address as queued and as seen by the cache
  typedef union packed {
    struct packed {
      logic [PTAG_W-1:0]  ptag;
      logic [VADDR_W-1:0] vaddr;
    } req;
    struct packed {
      logic [CTAG_W-1:0]     ctag;
      logic [INDEX_W-1:0]    index;
      logic [WORD_SEL_W-1:0] word_sel;
      logic [BYTE_W-1:0]     byte_off;
    } cache;
  } fetch_addr_u;

endpackage

/* icache_fe_properties.sv */
`timescale 1ns/1ps

module icache_fe_properties
  import icache_fe_pkg::*;
(
  input    logic               clk_i
  , input  logic               arst_n_i
  , input  logic [PADDR_W-1:0] cmd_addr_i
  , input  logic               cmd_v_i
  , input  logic               cmd_ready_i
  , input  logic               resp_ready_i
);

  int fail_count = 0;

  // Command holds with the same address until taken
  a_cmd_hold : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cmd_v_i && !cmd_ready_i |=> cmd_v_i && $stable(cmd_addr_i)
  ) else begin
    fail_count++;
    $error("memory command dropped or changed before acceptance");
  end

  a_cmd_resp_apart : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !(cmd_v_i && resp_ready_i)
  ) else begin
    fail_count++;
    $error("command valid and response ready high together");
  end

  // Block-aligned fill address
  a_cmd_aligned : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cmd_v_i |-> (cmd_addr_i[OFFSET_W-1:0] == '0)
  ) else begin
    fail_count++;
    $error("memory command address has nonzero offset bits");
  end

endmodule

bind icache_uce icache_fe_properties u_uce_props (
  .clk_i          (clk_i)
  , .arst_n_i     (arst_n_i)
  , .cmd_addr_i   (mem_cmd_addr_o)
  , .cmd_v_i      (mem_cmd_v_o)
  , .cmd_ready_i  (mem_cmd_ready_and_i)
  , .resp_ready_i (mem_resp_ready_and_o)
);

/* icache_fe_top.sv */
`timescale 1ns/1ps

module icache_fe_top
  import icache_fe_pkg::*;
(
  input    logic               clk_i
  , input  logic               arst_n_i

  , input  logic [VADDR_W-1:0] vaddr_i
  , input  logic [PTAG_W-1:0]  ptag_i
  , input  logic               vaddr_v_i
  , output logic               vaddr_ready_o

  , output logic [INSTR_W-1:0] data_o
  , output logic               data_v_o

  , output logic [PADDR_W-1:0] mem_cmd_addr_o
  , output logic               mem_cmd_v_o
  , input  logic               mem_cmd_ready_and_i

  , input  logic [FILL_W-1:0]  mem_resp_data_i
  , input  logic               mem_resp_v_i
  , input  logic               mem_resp_last_i
  , output logic               mem_resp_ready_and_o
);

  fetch_if fetch ();
  miss_if  miss ();

  // Replaying request queue
  fetch_replay_fifo u_fifo (
    .clk_i          (clk_i)
    , .arst_n_i     (arst_n_i)
    , .vaddr_i      (vaddr_i)
    , .ptag_i       (ptag_i)
    , .vaddr_v_i    (vaddr_v_i)
    , .vaddr_ready_o(vaddr_ready_o)
    , .fetch        (fetch.queue)
  );

  icache_pipe u_pipe (
    .clk_i      (clk_i)
    , .arst_n_i (arst_n_i)
    , .fetch    (fetch.cache)
    , .miss     (miss.cache)
    , .data_o   (data_o)
    , .data_v_o (data_v_o)
  );

  // Block fills from memory
  icache_uce u_uce (
    .clk_i                 (clk_i)
    , .arst_n_i            (arst_n_i)
    , .miss                (miss.engine)
    , .mem_cmd_addr_o      (mem_cmd_addr_o)
    , .mem_cmd_v_o         (mem_cmd_v_o)
    , .mem_cmd_ready_and_i (mem_cmd_ready_and_i)
    , .mem_resp_data_i     (mem_resp_data_i)
    , .mem_resp_v_i        (mem_resp_v_i)
    , .mem_resp_last_i     (mem_resp_last_i)
    , .mem_resp_ready_and_o(mem_resp_ready_and_o)
  );

endmodule

/* icache_pipe.sv */
`timescale 1ns/1ps

module icache_pipe
  import icache_fe_pkg::*;
(
  input    logic               clk_i
  , input  logic               arst_n_i

  , fetch_if.cache             fetch
  , miss_if.cache              miss

  , output logic [INSTR_W-1:0] data_o
  , output logic               data_v_o
);

  logic [CTAG_W-1:0]  tag_mem  [SETS];
  logic [BLOCK_W-1:0] data_mem [SETS];
  logic [SETS-1:0]    valid_r;

  // Tag lookup stage
  logic                                    tl_v_r;
  fetch_addr_u                             tl_addr_r;
  logic [CTAG_W-1:0]                       tl_tag_r;
  logic                                    tl_valid_r;
  logic [BLOCK_W/INSTR_W-1:0][INSTR_W-1:0] tl_data_r;
  logic                                    tl_hit;
  logic                                    tl_miss;

  // Tag verify stage
  logic               tv_v_r;
  logic               tv_hit_r;
  logic [INSTR_W-1:0] tv_word_r;

  logic               miss_pend_r;
  logic               req_v_r;
  logic [PADDR_W-1:0] req_addr_r;
  logic               ready;

  // No new lookups between a miss and its completion
  assign ready      = ~miss_pend_r & ~miss.busy;
  assign fetch.yumi = fetch.v & ready;

  always_ff @(posedge clk_i) begin
    tl_addr_r  <= fetch.entry;
    tl_tag_r   <= tag_mem[fetch.entry.cache.index];
    tl_valid_r <= valid_r[fetch.entry.cache.index];
    tl_data_r  <= data_mem[fetch.entry.cache.index];
  end

  assign tl_hit  = tl_valid_r & (tl_tag_r == tl_addr_r.cache.ctag);
  // A lookup killed by a roll is not a miss
  assign tl_miss = tl_v_r & ~tl_hit & ~fetch.roll;

  always_ff @(posedge clk_i) begin
    tv_word_r <= tl_data_r[tl_addr_r.cache.word_sel];
    if (tl_miss) begin
      req_addr_r <= {tl_addr_r.cache.ctag, tl_addr_r.cache.index, {OFFSET_W{1'b0}}};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tl_v_r   <= 1'b0;
      tv_v_r   <= 1'b0;
      tv_hit_r <= 1'b0;
    end else begin
      tl_v_r   <= fetch.yumi;
      tv_v_r   <= tl_v_r & ~fetch.roll;
      tv_hit_r <= tl_hit;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      miss_pend_r <= 1'b0;
      req_v_r     <= 1'b0;
    end else begin
      if (tl_miss) begin
        miss_pend_r <= 1'b1;
      end else if (miss.complete) begin
        miss_pend_r <= 1'b0;
      end
      if (tl_miss) begin
        req_v_r <= 1'b1;
      end else if (miss.req_yumi) begin
        req_v_r <= 1'b0;
      end
    end
  end

  // Fill writes tag and block together
  always_ff @(posedge clk_i) begin
    if (miss.fill_v) begin
      tag_mem[miss.fill_index]  <= miss.fill_tag;
      data_mem[miss.fill_index] <= miss.fill_data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_r <= '0;
    end else if (miss.fill_v) begin
      valid_r[miss.fill_index] <= 1'b1;
    end
  end

  assign data_o       = tv_word_r;
  assign data_v_o     = tv_v_r & tv_hit_r;
  assign fetch.commit = data_v_o;
  assign fetch.roll   = tv_v_r & ~tv_hit_r;

  assign miss.req_v    = req_v_r;
  assign miss.req_addr = req_addr_r;

endmodule

/* icache_uce.sv */
`timescale 1ns/1ps

module icache_uce
  import icache_fe_pkg::*;
(
  input    logic               clk_i
  , input  logic               arst_n_i

  , miss_if.engine             miss

  , output logic [PADDR_W-1:0] mem_cmd_addr_o
  , output logic               mem_cmd_v_o
  , input  logic               mem_cmd_ready_and_i

  , input  logic [FILL_W-1:0]  mem_resp_data_i
  , input  logic               mem_resp_v_i
  , input  logic               mem_resp_last_i
  , output logic               mem_resp_ready_and_o
);

  logic [UCE_STATE_W-1:0]            state_r;
  logic [UCE_STATE_W-1:0]            state_n;
  fetch_addr_u                       cmd_addr_r;
  logic [BEAT_W-1:0]                 beat_cnt_r;
  logic [FILL_BEATS-1:0][FILL_W-1:0] fill_buf_r;
  logic                              complete_r;
  logic                              beat;

  assign beat = mem_resp_v_i & mem_resp_ready_and_o;

  always_comb begin
    state_n = state_r;
    case (state_r)
      UCE_IDLE: begin
        if (miss.req_v) begin
          state_n = UCE_SEND;
        end
      end
      UCE_SEND: begin
        if (mem_cmd_ready_and_i) begin
          state_n = UCE_COLLECT;
        end
      end
      UCE_COLLECT: begin
        if (beat && mem_resp_last_i) begin
          state_n = UCE_FILL;
        end
      end
      UCE_FILL: begin
        state_n = UCE_IDLE;
      end
      default: begin
        state_n = UCE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r    <= UCE_IDLE;
      complete_r <= 1'b0;
      beat_cnt_r <= '0;
    end else begin
      state_r    <= state_n;
      // Complete follows the fill write by one cycle
      complete_r <= (state_r == UCE_FILL);
      if (miss.req_yumi) begin
        beat_cnt_r <= '0;
      end else if (beat) begin
        beat_cnt_r <= beat_cnt_r + 1'b1;
      end
    end
  end

  // First beat lands in the low word
  always_ff @(posedge clk_i) begin
    if (miss.req_yumi) begin
      cmd_addr_r <= miss.req_addr;
    end
    if (beat) begin
      fill_buf_r[beat_cnt_r] <= mem_resp_data_i;
    end
  end

  assign miss.req_yumi = (state_r == UCE_IDLE) & miss.req_v;
  assign miss.busy     = (state_r != UCE_IDLE) | complete_r;

  assign mem_cmd_addr_o       = cmd_addr_r;
  assign mem_cmd_v_o          = (state_r == UCE_SEND);
  assign mem_resp_ready_and_o = (state_r == UCE_COLLECT);

  assign miss.fill_v     = (state_r == UCE_FILL);
  assign miss.fill_index = cmd_addr_r.cache.index;
  assign miss.fill_tag   = cmd_addr_r.cache.ctag;
  assign miss.fill_data  = fill_buf_r;
  assign miss.complete   = complete_r;

endmodule

/* miss_if.sv */
`timescale 1ns/1ps

interface miss_if
  import icache_fe_pkg::*;
();

  // Block-aligned miss address, held until req_yumi
  logic               req_v;
  logic [PADDR_W-1:0] req_addr;
  logic               req_yumi;
  logic               busy;

  // One-cycle write of a whole block
  logic               fill_v;
  logic [INDEX_W-1:0] fill_index;
  logic [CTAG_W-1:0]  fill_tag;
  logic [BLOCK_W-1:0] fill_data;
  logic               complete;

  modport cache (
    output req_v
    , output req_addr
    , input  req_yumi
    , input  busy
    , input  fill_v
    , input  fill_index
    , input  fill_tag
    , input  fill_data
    , input  complete
  );

  modport engine (
    input    req_v
    , input  req_addr
    , output req_yumi
    , output busy
    , output fill_v
    , output fill_index
    , output fill_tag
    , output fill_data
    , output complete
  );

endinterface

/* tb_icache_fe.sv */
`timescale 1ns/1ps

module tb_icache_fe
  import icache_fe_pkg::*;
();

  logic               clk_i = 1'b0;
  logic               arst_n_i;
  logic [VADDR_W-1:0] vaddr_i;
  logic [PTAG_W-1:0]  ptag_i;
  logic               vaddr_v_i;
  logic               vaddr_ready_o;
  logic [INSTR_W-1:0] data_o;
  logic               data_v_o;
  logic [PADDR_W-1:0] mem_cmd_addr_o;
  logic               mem_cmd_v_o;
  logic               mem_cmd_ready_and_i = 1'b0;
  logic [FILL_W-1:0]  mem_resp_data_i = '0;
  logic               mem_resp_v_i = 1'b0;
  logic               mem_resp_last_i = 1'b0;
  logic               mem_resp_ready_and_o;

  integer seed = 44371;
  int errors = 0;
  int mon_errors = 0;
  int model_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  logic [31:0] exp_q [$];

  // Memory model state
  int cmd_stall = 0;
  int beat_gap = 0;
  int stall_cnt = 0;
  int gap_cnt = 0;
  int beat_idx = 0;
  int cmd_count = 0;
  logic               pending = 1'b0;
  logic [PADDR_W-1:0] pend_addr = '0;
  logic [PADDR_W-1:0] hold_addr = '0;
  logic [PADDR_W-1:0] beat_addr;
  logic [PADDR_W-1:0] last_cmd_addr = '0;

  icache_fe_top u_dut (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] expected_word(input logic [7:0] ptag, input logic [11:0] vaddr);
    return {12'hC0D, ptag, vaddr[11:2], 2'b00};
  endfunction

  function automatic int check_eq(input string name, input logic [31:0] expv,
                                  input logic [31:0] actv);
    int bad;
    bad = 0;
    assert (actv === expv) else begin
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expv, actv);
      bad = 1;
    end
    return bad;
  endfunction

  function automatic int total_errors();
    return errors + mon_errors + model_errors + u_dut.u_uce.u_uce_props.fail_count;
  endfunction

  // Memory side, driven on the falling edge
  always @(negedge clk_i) begin
    mem_cmd_ready_and_i = 1'b0;
    mem_resp_v_i        = 1'b0;
    mem_resp_last_i     = 1'b0;
    if (!pending && mem_cmd_v_o) begin
      if (stall_cnt == 0) begin
        hold_addr = mem_cmd_addr_o;
      end
      model_errors += check_eq("mem_cmd_addr_o", 32'(hold_addr), 32'(mem_cmd_addr_o));
      if (stall_cnt < cmd_stall) begin
        stall_cnt++;
      end else begin
        mem_cmd_ready_and_i = 1'b1;
        pend_addr     = mem_cmd_addr_o;
        last_cmd_addr = mem_cmd_addr_o;
        pending       = 1'b1;
        beat_idx      = 0;
        gap_cnt       = 0;
        stall_cnt     = 0;
        cmd_count++;
      end
    end else if (pending && mem_resp_ready_and_o) begin
      if (gap_cnt < beat_gap) begin
        gap_cnt++;
      end else begin
        // Beat k carries the word at block address plus 4k
        beat_addr       = pend_addr | (20'(beat_idx) << 2);
        mem_resp_data_i = {12'hC0D, beat_addr[19:2], 2'b00};
        mem_resp_v_i    = 1'b1;
        mem_resp_last_i = (beat_idx == FILL_BEATS - 1);
        beat_idx++;
        gap_cnt = 0;
        if (beat_idx == FILL_BEATS) begin
          pending = 1'b0;
        end
      end
    end
  end

  // Scoreboard
  always @(negedge clk_i) begin
    if (arst_n_i && data_v_o) begin
      if (exp_q.size() == 0) begin
        $display("%0t: data_v_o rose with no request outstanding", $time);
        mon_errors++;
      end else begin
        mon_errors += check_eq("data_o", exp_q.pop_front(), data_o);
      end
    end
  end

  task automatic send_req(input logic [7:0] ptag, input logic [11:0] vaddr);
    int t;
    t = 0;
    while (!vaddr_ready_o && t < 300) begin
      @(negedge clk_i);
      t++;
    end
    if (!vaddr_ready_o) begin
      $display("%0t: request queue never accepted a request", $time);
      errors++;
    end else begin
      vaddr_v_i = 1'b1;
      ptag_i    = ptag;
      vaddr_i   = vaddr;
      exp_q.push_back(expected_word(ptag, vaddr));
      @(negedge clk_i);
      vaddr_v_i = 1'b0;
    end
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < 500) begin
      @(negedge clk_i);
      t++;
    end
    if (exp_q.size() != 0) begin
      $display("%0t: %0d expected words never came out", $time, exp_q.size());
      errors++;
    end
    repeat (4) @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (total_errors() == err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, total_errors() - err0);
      tests_failed++;
    end
  endtask

  task automatic reset_state_test();
    int err0;
    err0 = total_errors();
    for (int i = 0; i < 10; i++) begin
      errors += check_eq("data_v_o", 0, 32'(data_v_o));
      errors += check_eq("mem_cmd_v_o", 0, 32'(mem_cmd_v_o));
      errors += check_eq("mem_resp_ready_and_o", 0, 32'(mem_resp_ready_and_o));
      errors += check_eq("vaddr_ready_o", 1, 32'(vaddr_ready_o));
      @(negedge clk_i);
    end
    report_test("reset state", err0);
  endtask

  task automatic cold_miss_test();
    int err0;
    int cnt0;
    err0 = total_errors();
    cnt0 = cmd_count;
    send_req(8'h3A, 12'h124);
    drain();
    errors += check_eq("mem_cmd count", 1, cmd_count - cnt0);
    errors += check_eq("mem_cmd_addr_o", 32'h3A120, 32'(last_cmd_addr));
    // Other word of the same block
    send_req(8'h3A, 12'h120);
    drain();
    errors += check_eq("mem_cmd count", 1, cmd_count - cnt0);
    report_test("cold miss", err0);
  endtask

  task automatic stream_test();
    int err0;
    int cnt0;
    logic [31:0] rnd;
    logic [3:0]  used;
    err0 = total_errors();
    cnt0 = cmd_count;
    used = '0;
    // Four blocks in sets 8 to 11
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      used[rnd[1:0]] = 1'b1;
      send_req(8'h61, {7'b0010010, rnd[1:0], rnd[2], 2'b00});
    end
    drain();
    errors += check_eq("mem_cmd count", $countones(used), cmd_count - cnt0);
    report_test("in-order stream", err0);
  endtask

  task automatic replay_test();
    int err0;
    int cnt0;
    err0 = total_errors();
    send_req(8'h70, 12'h360);
    drain();
    cnt0 = cmd_count;
    // Miss first, then hits behind it
    send_req(8'h71, 12'h368);
    send_req(8'h70, 12'h364);
    send_req(8'h70, 12'h360);
    send_req(8'h71, 12'h36C);
    send_req(8'h70, 12'h364);
    drain();
    errors += check_eq("mem_cmd count", 1, cmd_count - cnt0);
    report_test("replay after miss", err0);
  endtask

  task automatic backpressure_test();
    int err0;
    int cnt0;
    err0 = total_errors();
    cnt0 = cmd_count;
    cmd_stall = 6;
    beat_gap  = 3;
    send_req(8'h82, 12'h0F0);
    send_req(8'h82, 12'h0F4);
    drain();
    errors += check_eq("mem_cmd count", 1, cmd_count - cnt0);
    cmd_stall = 0;
    beat_gap  = 0;
    report_test("memory back-pressure", err0);
  endtask

  task automatic queue_full_test();
    int err0;
    int cnt0;
    err0 = total_errors();
    cnt0 = cmd_count;
    cmd_stall = 1000;
    for (int i = 0; i < 8; i++) begin
      send_req(8'h93, 12'h400 + 12'(i * 4));
    end
    errors += check_eq("vaddr_ready_o", 0, 32'(vaddr_ready_o));
    cmd_stall = 0;
    drain();
    errors += check_eq("mem_cmd count", 4, cmd_count - cnt0);
    report_test("queue full", err0);
  endtask

  initial begin
    arst_n_i  = 1'b0;
    vaddr_i   = '0;
    ptag_i    = '0;
    vaddr_v_i = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    reset_state_test();
    cold_miss_test();
    stream_test();
    replay_test();
    backpressure_test();
    queue_full_test();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
